// ==== pcoeffPkg.sv ====
package pcoeffPkg;

    // four-variable truth tables, bit k of the index is variable k
    localparam int tableWidth = 16;
    localparam int permCount = 6;
    localparam int permIdxWidth = $clog2(permCount);

    // largest term is 2**16
    localparam int termWidth = 17;
    localparam int sumWidth = 48;
    localparam int countWidth = 4;

    // images of variables 1, 2, 3 packed as {img3, img2, img1}
    // lexicographic over (img1, img2, img3), identity first
    localparam logic [5:0] permOrder [permCount] = '{
        {2'd3, 2'd2, 2'd1},
        {2'd2, 2'd3, 2'd1},
        {2'd3, 2'd1, 2'd2},
        {2'd1, 2'd3, 2'd2},
        {2'd2, 2'd1, 2'd3},
        {2'd1, 2'd2, 2'd3}
    };

    function automatic logic [tableWidth-1:0] permuteTable(
        input logic [tableWidth-1:0] inTable,
        input logic [permIdxWidth-1:0] permNum
    );
        logic [5:0] images;
        logic [3:0] srcIdx;
        logic [3:0] dstIdx;
        logic [tableWidth-1:0] outTable;
        images = permOrder[permNum];
        outTable = '0;
        for (int i = 0; i < tableWidth; i++) begin
            srcIdx = 4'(i);
            // variable 0 stays in place
            dstIdx = '0;
            dstIdx[0] = srcIdx[0];
            dstIdx[images[1:0]] = srcIdx[1];
            dstIdx[images[3:2]] = srcIdx[2];
            dstIdx[images[5:4]] = srcIdx[3];
            outTable[dstIdx] = inTable[i];
        end
        return outTable;
    endfunction

endpackage

// ==== permutationGenerator.sv ====
`timescale 1ns/1ps

module permutationGenerator (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [pcoeffPkg::tableWidth-1:0] bot,
    input  logic                             writeBot,
    input  logic                             slowDownInput,
    output logic                             readyForInputBot,
    output logic [pcoeffPkg::tableWidth-1:0] permutedBot,
    output logic                             permutedBotValid,
    output logic                             batchDone
);
    import pcoeffPkg::*;

    logic [tableWidth-1:0] botReg;
    logic [permIdxWidth-1:0] permIdx;
    logic busy;
    logic started;
    logic lastStep;
    logic accept;

    // ####################################################################
    // handshake
    // ####################################################################

    assign lastStep = busy && (permIdx == permIdxWidth'(permCount - 1));

    // next bot may land on the cycle that emits the sixth permutation
    assign readyForInputBot = started && (!busy || lastStep) && !slowDownInput;
    assign accept = writeBot && readyForInputBot;

    // ####################################################################
    // permutation counter
    // ####################################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            started <= 1'b0;
            busy <= 1'b0;
            permIdx <= '0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                busy <= 1'b1;
                permIdx <= '0;
            end else if (lastStep) begin
                busy <= 1'b0;
            end else if (busy) begin
                permIdx <= permIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            botReg <= bot;
        end
    end

    assign permutedBot = permuteTable(botReg, permIdx);
    assign permutedBotValid = busy;
    assign batchDone = lastStep;

    // a running batch steps through every permutation, no restart and no skip
    assert property (@(posedge clk) disable iff (!rstN)
        permutedBotValid && !batchDone |=>
            permutedBotValid && (permIdx == $past(permIdx) + 1'b1))
        else $error("batch interrupted before its sixth permutation");

endmodule

// ==== pcoeffTermStage.sv ====
`timescale 1ns/1ps

module pcoeffTermStage (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [pcoeffPkg::tableWidth-1:0] top,
    input  logic [pcoeffPkg::tableWidth-1:0] permutedBot,
    input  logic                             permutedBotValid,
    input  logic                             batchDone,
    output logic                             termValid,
    output logic [pcoeffPkg::termWidth-1:0]  term,
    output logic                             termPassed,
    output logic                             termLast
);
    import pcoeffPkg::*;

    localparam int popWidth = $clog2(tableWidth + 1);

    logic subset;
    logic [popWidth-1:0] freeBits;
    logic s1Valid;
    logic s1Last;
    logic s1Subset;
    logic [popWidth-1:0] s1Pop;

    // bot fits inside top when it sets nothing that top clears
    assign subset = (permutedBot & ~top) == '0;
    assign freeBits = popWidth'($countones(top & ~permutedBot));

    // stage one: subset flag and free-bit count
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s1Last <= 1'b0;
        end else begin
            s1Valid <= permutedBotValid;
            s1Last <= permutedBotValid && batchDone;
        end
    end

    always_ff @(posedge clk) begin
        s1Subset <= subset;
        s1Pop <= freeBits;
    end

    // stage two: power of two, zero on a failed subset test
    always_ff @(posedge clk) begin
        if (!rstN) begin
            termValid <= 1'b0;
            termLast <= 1'b0;
        end else begin
            termValid <= s1Valid;
            termLast <= s1Last;
        end
    end

    always_ff @(posedge clk) begin
        termPassed <= s1Subset;
        term <= s1Subset ? (termWidth'(1) << s1Pop) : '0;
    end

endmodule

// ==== batchAccumulator.sv ====
`timescale 1ns/1ps

module batchAccumulator (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             termValid,
    input  logic [pcoeffPkg::termWidth-1:0]  term,
    input  logic                             termPassed,
    input  logic                             termLast,
    input  logic                             takeResult,
    output logic                             slowDownInput,
    output logic                             resultReady,
    output logic [pcoeffPkg::sumWidth-1:0]   resultSum,
    output logic [pcoeffPkg::countWidth-1:0] resultCount
);
    import pcoeffPkg::*;

    logic [sumWidth-1:0] runSum;
    logic [countWidth-1:0] runCount;
    logic [sumWidth-1:0] nextSum;
    logic [countWidth-1:0] nextCount;
    logic [sumWidth-1:0] qSum [2];
    logic [countWidth-1:0] qCount [2];
    logic wrPtr;
    logic rdPtr;
    logic [1:0] fill;
    logic push;

    // ####################################################################
    // running sum per bot
    // ####################################################################

    assign nextSum = runSum + sumWidth'(term);
    assign nextCount = runCount + countWidth'(termPassed);
    assign push = termValid && termLast;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            runSum <= '0;
            runCount <= '0;
        end else if (termValid) begin
            if (termLast) begin
                runSum <= '0;
                runCount <= '0;
            end else begin
                runSum <= nextSum;
                runCount <= nextCount;
            end
        end
    end

    // ####################################################################
    // two-entry result queue
    // ####################################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            fill <= '0;
        end else begin
            if (push) begin
                wrPtr <= ~wrPtr;
            end
            if (takeResult) begin
                rdPtr <= ~rdPtr;
            end
            fill <= fill + {1'b0, push} - {1'b0, takeResult};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qSum[wrPtr] <= nextSum;
            qCount[wrPtr] <= nextCount;
        end
    end

    // the second entry is kept for a bot already in flight
    assign resultReady = fill != 2'd0;
    assign slowDownInput = fill != 2'd0;
    assign resultSum = qSum[rdPtr];
    assign resultCount = qCount[rdPtr];

    assert property (@(posedge clk) disable iff (!rstN)
        push |-> fill != 2'd2)
        else $error("result pushed into a full queue");

    assert property (@(posedge clk) disable iff (!rstN)
        takeResult |-> resultReady)
        else $error("result taken from an empty queue");

endmodule

// ==== resultCollector.sv ====
`timescale 1ns/1ps

module resultCollector #(
    parameter int grabGap = 10,
    parameter int grabDelay = 8
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             resultReady,
    input  logic [pcoeffPkg::sumWidth-1:0]   resultSum,
    input  logic [pcoeffPkg::countWidth-1:0] resultCount,
    input  logic                             grabResults,
    output logic                             takeResult,
    output logic                             resultsAvailable,
    output logic [pcoeffPkg::sumWidth-1:0]   pcoeffSum,
    output logic [pcoeffPkg::countWidth-1:0] pcoeffCount
);
    import pcoeffPkg::*;

    localparam int gapWidth = $clog2(grabGap + 1);

    logic [gapWidth-1:0] gapCount;
    logic gapReached;
    logic [grabDelay-1:0] takeLine;
    logic arrive;
    logic [sumWidth-1:0] pendSum;
    logic [countWidth-1:0] pendCount;

    // ####################################################################
    // take pacing
    // ####################################################################

    assign gapReached = gapCount == gapWidth'(grabGap);
    assign takeResult = !resultsAvailable && resultReady && gapReached;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            gapCount <= '0;
        end else if (takeResult) begin
            gapCount <= '0;
        end else if (!gapReached) begin
            gapCount <= gapCount + 1'b1;
        end
    end

    // ####################################################################
    // transfer delay and output hold
    // ####################################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            takeLine <= '0;
        end else begin
            takeLine <= (takeLine << 1) | grabDelay'(takeResult);
        end
    end

    assign arrive = takeLine[grabDelay-1];

    // queue head moves on at the take, so hold its value for the transfer
    always_ff @(posedge clk) begin
        if (takeResult) begin
            pendSum <= resultSum;
            pendCount <= resultCount;
        end
        if (arrive) begin
            pcoeffSum <= pendSum;
            pcoeffCount <= pendCount;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultsAvailable <= 1'b0;
        end else if (arrive) begin
            resultsAvailable <= 1'b1;
        end else if (grabResults) begin
            resultsAvailable <= 1'b0;
        end
    end

    // pacing must keep a second transfer from landing on a held result
    assert property (@(posedge clk) disable iff (!rstN)
        arrive |-> !resultsAvailable)
        else $error("result arrived while previous one still held");

endmodule

// ==== fullPermutationPipeline.sv ====
`timescale 1ns/1ps

module fullPermutationPipeline #(
    parameter int grabGap = 10,
    parameter int grabDelay = 8
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [pcoeffPkg::tableWidth-1:0] top,
    input  logic [pcoeffPkg::tableWidth-1:0] bot,
    input  logic                             writeBot,
    input  logic                             grabResults,
    output logic                             readyForInputBot,
    output logic                             resultsAvailable,
    output logic [pcoeffPkg::sumWidth-1:0]   pcoeffSum,
    output logic [pcoeffPkg::countWidth-1:0] pcoeffCount
);
    import pcoeffPkg::*;

    logic [tableWidth-1:0] permutedBot;
    logic permutedBotValid;
    logic batchDone;
    logic slowDownInput;
    logic termValid;
    logic [termWidth-1:0] term;
    logic termPassed;
    logic termLast;
    logic takeResult;
    logic resultReady;
    logic [sumWidth-1:0] resultSum;
    logic [countWidth-1:0] resultCount;

    permutationGenerator permGen_i (
        .clk(clk),
        .rstN(rstN),
        .bot(bot),
        .writeBot(writeBot),
        .slowDownInput(slowDownInput),
        .readyForInputBot(readyForInputBot),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchDone(batchDone)
    );

    pcoeffTermStage termStage_i (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchDone(batchDone),
        .termValid(termValid),
        .term(term),
        .termPassed(termPassed),
        .termLast(termLast)
    );

    batchAccumulator accum_i (
        .clk(clk),
        .rstN(rstN),
        .termValid(termValid),
        .term(term),
        .termPassed(termPassed),
        .termLast(termLast),
        .takeResult(takeResult),
        .slowDownInput(slowDownInput),
        .resultReady(resultReady),
        .resultSum(resultSum),
        .resultCount(resultCount)
    );

    resultCollector #(
        .grabGap(grabGap),
        .grabDelay(grabDelay)
    ) collector_i (
        .clk(clk),
        .rstN(rstN),
        .resultReady(resultReady),
        .resultSum(resultSum),
        .resultCount(resultCount),
        .grabResults(grabResults),
        .takeResult(takeResult),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen #(
    parameter realtime halfPeriod = 2ns
) (
    output logic clk
);

    // free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(halfPeriod) clk = ~clk;
        end
    end

endmodule

// ==== fullPermutationPipelineTb.sv ====
`timescale 1ns/1ps

module fullPermutationPipelineTb;

    localparam int fixedRows = 8;
    localparam int rowCount = 20;
    localparam int rowBoundCycles = 150;
    localparam int stallCycles = 12;

    logic clk;
    logic rstN;
    logic [15:0] top;
    logic [15:0] bot;
    logic writeBot;
    logic grabResults;
    logic readyForInputBot;
    logic resultsAvailable;
    logic [47:0] pcoeffSum;
    logic [3:0] pcoeffCount;

    // stimulus table, expected columns filled from the model
    string rowName [rowCount];
    logic [15:0] rowTop [rowCount];
    logic [15:0] rowBot [rowCount];
    int rowGrab [rowCount];
    logic rowChained [rowCount];
    logic [47:0] rowSum [rowCount];
    logic [3:0] rowCnt [rowCount];

    logic [31:0] lfsrState;
    int doneCount;
    logic sawStall;

    tbClockGen clkGen_i (.clk(clk));

    fullPermutationPipeline dut_i (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .bot(bot),
        .writeBot(writeBot),
        .grabResults(grabResults),
        .readyForInputBot(readyForInputBot),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    // ####################################################################
    // model and helpers
    // ####################################################################

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] drawBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int n = 0; n < width; n++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // all six images of variables 1..3, so the total does not depend on order
    function automatic logic [51:0] expectedResult(input logic [15:0] topT,
                                                   input logic [15:0] botT);
        logic [15:0] permT;
        logic [3:0] dst;
        logic [47:0] sum;
        logic [3:0] cnt;
        int img [4];
        sum = '0;
        cnt = '0;
        img[0] = 0;
        for (int a = 1; a < 4; a++) begin
            for (int b = 1; b < 4; b++) begin
                for (int c = 1; c < 4; c++) begin
                    if (a != b && a != c && b != c) begin
                        img[1] = a;
                        img[2] = b;
                        img[3] = c;
                        permT = '0;
                        for (int i = 0; i < 16; i++) begin
                            dst = '0;
                            for (int k = 0; k < 4; k++) begin
                                dst[img[k]] = i[k];
                            end
                            permT[dst] = botT[i];
                        end
                        if ((permT & ~topT) == 16'h0) begin
                            sum += 48'(1) << $countones(topT & ~permT);
                            cnt++;
                        end
                    end
                end
            end
        end
        return {cnt, sum};
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic addRow(input int r, input string name, input logic [15:0] topT,
                          input logic [15:0] botT, input int grab, input logic chained);
        rowName[r] = name;
        rowTop[r] = topT;
        rowBot[r] = botT;
        rowGrab[r] = grab;
        rowChained[r] = chained;
        {rowCnt[r], rowSum[r]} = expectedResult(topT, botT);
    endtask

    // ####################################################################
    // run
    // ####################################################################

    initial begin
        logic [15:0] randTop;
        rstN = 1'b0;
        top = '0;
        bot = '0;
        writeBot = 1'b0;
        grabResults = 1'b0;
        doneCount = 0;
        sawStall = 1'b0;
        lfsrState = 32'hce678b0f;

        addRow(0, "allOnesTop", 16'hffff, 16'h0000, 2, 1'b0);
        addRow(1, "notSubset", 16'h5555, 16'h0002, 1, 1'b0);
        addRow(2, "symmetricBot", 16'hffff, 16'h8001, 0, 1'b0);
        addRow(3, "partialFit", 16'h000f, 16'h0004, 3, 1'b0);
        // burst held off at the output, same top throughout
        addRow(4, "burst0", 16'hffff, 16'h0001, 60, 1'b0);
        addRow(5, "burst1", 16'hffff, 16'h0003, 40, 1'b1);
        addRow(6, "burst2", 16'hffff, 16'h0007, 5, 1'b1);
        addRow(7, "burst3", 16'hffff, 16'h000f, 0, 1'b1);
        for (int r = fixedRows; r < rowCount; r++) begin
            randTop = 16'(drawBits(16));
            // odd rows keep bot inside top so that some terms are non-zero
            if (r % 2 == 1) begin
                addRow(r, $sformatf("random%0d", r), randTop,
                       16'(drawBits(16)) & randTop, int'(drawBits(3)), 1'b0);
            end else begin
                addRow(r, $sformatf("random%0d", r), randTop,
                       16'(drawBits(16)), int'(drawBits(3)), 1'b0);
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        fork
            begin : writer
                int waitCycles;
                for (int r = 0; r < rowCount; r++) begin
                    if (!rowChained[r]) begin
                        while (doneCount != r) @(negedge clk);
                        top = rowTop[r];
                    end
                    waitCycles = 0;
                    while (!readyForInputBot) begin
                        @(negedge clk);
                        waitCycles++;
                    end
                    if (waitCycles > stallCycles) begin
                        sawStall = 1'b1;
                    end
                    bot = rowBot[r];
                    writeBot = 1'b1;
                    @(negedge clk);
                    writeBot = 1'b0;
                end
            end
            begin : reader
                for (int r = 0; r < rowCount; r++) begin
                    while (!resultsAvailable) @(negedge clk);
                    compareValue({rowName[r], " sum"}, 64'(rowSum[r]), 64'(pcoeffSum));
                    compareValue({rowName[r], " count"}, 64'(rowCnt[r]), 64'(pcoeffCount));
                    repeat (rowGrab[r]) @(negedge clk);
                    grabResults = 1'b1;
                    @(negedge clk);
                    grabResults = 1'b0;
                    doneCount++;
                end
            end
        join

        compareValue("burst stall", 64'(1), 64'(sawStall));
        $display("Finished with no errors");
        $finish;
    end

    initial begin : watchdog
        repeat (rowCount * rowBoundCycles) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived", doneCount, rowCount);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== list.f ====
pcoeffPkg.sv
permutationGenerator.sv
pcoeffTermStage.sv
batchAccumulator.sv
resultCollector.sv
fullPermutationPipeline.sv
tbClockGen.sv
fullPermutationPipelineTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= fullPermutationPipelineTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
